// File: hw/hangmanPkg.sv
package hangmanPkg;

    // one ASCII character
    typedef logic [7:0] letterT;

    // five letters, position 0 in the top byte
    typedef logic [39:0] wordT;

    // one bit per position, bit 0 is position 0
    typedef logic [4:0] posMaskT;

    typedef logic [2:0] countT;

    localparam int WORD_LEN = 5;
    localparam countT MAX_MISTAKES = 3'd6;
    localparam letterT HIDDEN_CHAR = 8'h5f;

    typedef enum logic [3:0] {
        SET,
        READY,
        L0,
        L1,
        L2,
        L3,
        L4,
        STOP,
        OVER
    } phaseT;

    typedef struct packed {
        countT   mistakes;
        countT   correct;
        posMaskT lastHit;
        posMaskT revealed;
        logic    won;
        logic    lost;
        logic    ready;
        wordT    maskedWord;
    } gameStatusT;

    typedef struct packed {
        logic   valid;
        letterT letter;
    } normLetterT;

    // fold lowercase to uppercase, flag anything that is not a letter
    function automatic normLetterT normLetter(input letterT c);
        normLetterT result;
        result.letter = c;
        result.valid = 1'b0;
        if (c >= 8'h61 && c <= 8'h7a) begin
            result.letter = c - 8'h20;
            result.valid = 1'b1;
        end else if (c >= 8'h41 && c <= 8'h5a) begin
            result.valid = 1'b1;
        end
        return result;
    endfunction

endpackage

// File: hw/wordLoader.sv
`timescale 1ns/1ps

module wordLoader (
    input  logic                clk,
    input  logic                nRst,
    input  logic                wordReq,
    input  hangmanPkg::letterT  wordLetter,
    output logic                wordAck,
    input  logic                loadAllowed,
    output logic                newWord,
    output logic                wordFull,
    output hangmanPkg::wordT    word
);

    typedef enum logic {
        LOAD_IDLE,
        LOAD_ACK
    } loadStateT;

    loadStateT              state;
    logic [2:0]             letterCnt;
    hangmanPkg::normLetterT wordNorm;
    hangmanPkg::wordT       shiftReg;
    logic                   take;
    logic                   lastLetter;

    assign wordNorm = hangmanPkg::normLetter(wordLetter);

    // only look at a request while the game lets a word in
    assign take = (state == LOAD_IDLE) && wordReq && loadAllowed;
    assign lastLetter = (letterCnt == 3'(hangmanPkg::WORD_LEN - 1));

    assign wordAck = (state == LOAD_ACK);
    assign word = shiftReg;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state <= LOAD_IDLE;
            letterCnt <= '0;
            newWord <= 1'b0;
            wordFull <= 1'b0;
        end else begin
            newWord <= 1'b0;
            wordFull <= 1'b0;
            case (state)
                LOAD_IDLE: begin
                    if (take) begin
                        state <= LOAD_ACK;
                        // non-letters still get an ack, just nothing else
                        if (wordNorm.valid) begin
                            newWord <= (letterCnt == 3'd0);
                            if (lastLetter) begin
                                letterCnt <= '0;
                                wordFull <= 1'b1;
                            end else begin
                                letterCnt <= letterCnt + 3'd1;
                            end
                        end
                    end
                end
                LOAD_ACK: begin
                    if (!wordReq) begin
                        state <= LOAD_IDLE;
                    end
                end
                default: begin
                    state <= LOAD_IDLE;
                end
            endcase
        end
    end

    // first letter shifts up to the top byte
    always_ff @(posedge clk) begin
        if (take && wordNorm.valid) begin
            shiftReg <= {shiftReg[31:0], wordNorm.letter};
        end
    end

endmodule

// File: hw/gameLogic.sv
`timescale 1ns/1ps

module gameLogic (
    input  logic                 clk,
    input  logic                 nRst,
    input  logic                 guessReq,
    input  hangmanPkg::letterT   guessLetter,
    output logic                 guessAck,
    output logic                 guessRefused,
    input  logic                 newWord,
    input  logic                 wordFull,
    input  hangmanPkg::wordT     word,
    input  logic                 allRevealed,
    output logic                 loadAllowed,
    output logic                 hitValid,
    output hangmanPkg::posMaskT  hitMask,
    output hangmanPkg::countT    mistakes,
    output hangmanPkg::countT    correct,
    output hangmanPkg::posMaskT  lastHit,
    output logic                 lost,
    output logic                 ready
);

    hangmanPkg::phaseT      phase;
    hangmanPkg::phaseT      nextPhase;
    hangmanPkg::wordT       wordReg;
    hangmanPkg::letterT     guessReg;
    hangmanPkg::posMaskT    hitAcc;
    hangmanPkg::posMaskT    hitNext;
    hangmanPkg::normLetterT guessNorm;
    logic [1:0]             stopStep;
    logic                   guessNew;
    logic                   guessTaken;
    logic                   guessRefuse;
    logic                   verdict;

    assign guessNorm = hangmanPkg::normLetter(guessLetter);

    // a request counts once, while the previous ack is gone
    assign guessNew = guessReq && !guessAck;
    assign guessTaken = guessNew && (phase == hangmanPkg::READY) && guessNorm.valid;
    assign guessRefuse = guessNew &&
                         ((phase == hangmanPkg::SET) ||
                          (phase == hangmanPkg::OVER) ||
                          ((phase == hangmanPkg::READY) && !guessNorm.valid));

    // third STOP cycle, the tracker result is in by now
    assign verdict = (phase == hangmanPkg::STOP) && (stopStep == 2'd2);

    assign loadAllowed = (phase == hangmanPkg::SET) || (phase == hangmanPkg::OVER);
    assign ready = (phase == hangmanPkg::READY);
    assign hitMask = lastHit;

    // one position compared per cycle
    always_comb begin
        nextPhase = phase;
        hitNext = hitAcc;
        case (phase)
            hangmanPkg::SET: begin
                if (wordFull) begin
                    nextPhase = hangmanPkg::READY;
                end
            end
            hangmanPkg::READY: begin
                if (guessTaken) begin
                    hitNext = '0;
                    nextPhase = hangmanPkg::L0;
                end
            end
            hangmanPkg::L0: begin
                hitNext[0] = (guessReg == wordReg[39:32]);
                nextPhase = hangmanPkg::L1;
            end
            hangmanPkg::L1: begin
                hitNext[1] = (guessReg == wordReg[31:24]);
                nextPhase = hangmanPkg::L2;
            end
            hangmanPkg::L2: begin
                hitNext[2] = (guessReg == wordReg[23:16]);
                nextPhase = hangmanPkg::L3;
            end
            hangmanPkg::L3: begin
                hitNext[3] = (guessReg == wordReg[15:8]);
                nextPhase = hangmanPkg::L4;
            end
            hangmanPkg::L4: begin
                hitNext[4] = (guessReg == wordReg[7:0]);
                nextPhase = hangmanPkg::STOP;
            end
            hangmanPkg::STOP: begin
                if (verdict) begin
                    if (allRevealed || (mistakes == hangmanPkg::MAX_MISTAKES)) begin
                        nextPhase = hangmanPkg::OVER;
                    end else begin
                        nextPhase = hangmanPkg::READY;
                    end
                end
            end
            hangmanPkg::OVER: begin
                nextPhase = hangmanPkg::OVER;
            end
            default: begin
                nextPhase = hangmanPkg::SET;
            end
        endcase
        // a fresh word restarts the game
        if (newWord) begin
            nextPhase = hangmanPkg::SET;
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            phase <= hangmanPkg::SET;
            stopStep <= '0;
            guessAck <= 1'b0;
            guessRefused <= 1'b0;
            hitValid <= 1'b0;
            mistakes <= '0;
            correct <= '0;
            lastHit <= '0;
            lost <= 1'b0;
        end else begin
            phase <= nextPhase;
            hitValid <= 1'b0;

            if (phase == hangmanPkg::STOP) begin
                stopStep <= stopStep + 2'd1;
            end else begin
                stopStep <= '0;
            end

            // score on the first STOP cycle
            if ((phase == hangmanPkg::STOP) && (stopStep == 2'd0)) begin
                hitValid <= 1'b1;
                lastHit <= hitAcc;
                if (|hitAcc) begin
                    if (correct != 3'd7) begin
                        correct <= correct + 3'd1;
                    end
                end else begin
                    mistakes <= mistakes + 3'd1;
                end
            end

            if (verdict && (mistakes == hangmanPkg::MAX_MISTAKES)) begin
                lost <= 1'b1;
            end

            // guess channel, ack held until req drops
            if (guessAck) begin
                if (!guessReq) begin
                    guessAck <= 1'b0;
                    guessRefused <= 1'b0;
                end
            end else if (guessRefuse) begin
                guessAck <= 1'b1;
                guessRefused <= 1'b1;
            end else if (verdict) begin
                guessAck <= 1'b1;
            end

            if (newWord) begin
                mistakes <= '0;
                correct <= '0;
                lastHit <= '0;
                lost <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        hitAcc <= hitNext;
        if (guessTaken) begin
            guessReg <= guessNorm.letter;
        end
        if (wordFull) begin
            wordReg <= word;
        end
    end

endmodule

// File: hw/revealTracker.sv
`timescale 1ns/1ps

module revealTracker (
    input  logic                 clk,
    input  logic                 nRst,
    input  logic                 newWord,
    input  logic                 wordFull,
    input  hangmanPkg::wordT     word,
    input  logic                 hitValid,
    input  hangmanPkg::posMaskT  hitMask,
    output logic                 allRevealed,
    output logic                 won,
    output hangmanPkg::posMaskT  revealed,
    output hangmanPkg::wordT     maskedWord
);

    hangmanPkg::wordT    wordReg;
    hangmanPkg::posMaskT revealNext;

    // hits stick across guesses
    assign revealNext = revealed | hitMask;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            revealed <= '0;
            allRevealed <= 1'b0;
        end else if (newWord) begin
            revealed <= '0;
            allRevealed <= 1'b0;
        end else if (hitValid) begin
            revealed <= revealNext;
            allRevealed <= &revealNext;
        end
    end

    always_ff @(posedge clk) begin
        if (wordFull) begin
            wordReg <= word;
        end
    end

    // every position showing means the game is won
    assign won = allRevealed;

    // position i sits at byte WORD_LEN-1-i, counted from the bottom
    for (genvar i = 0; i < hangmanPkg::WORD_LEN; i++) begin : genMask
        localparam int LSB = (hangmanPkg::WORD_LEN - 1 - i) * 8;

        assign maskedWord[LSB +: 8] = revealed[i] ? wordReg[LSB +: 8]
                                                  : hangmanPkg::HIDDEN_CHAR;
    end

endmodule

// File: hw/hangmanTop.sv
`timescale 1ns/1ps

module hangmanTop (
    input  logic                   clk,
    input  logic                   nRst,
    input  logic                   wordReq,
    input  hangmanPkg::letterT     wordLetter,
    output logic                   wordAck,
    input  logic                   guessReq,
    input  hangmanPkg::letterT     guessLetter,
    output logic                   guessAck,
    output logic                   guessRefused,
    output hangmanPkg::gameStatusT status
);

    logic                loadAllowed;
    logic                newWord;
    logic                wordFull;
    hangmanPkg::wordT    word;
    logic                allRevealed;
    logic                hitValid;
    hangmanPkg::posMaskT hitMask;
    hangmanPkg::countT   mistakes;
    hangmanPkg::countT   correct;
    hangmanPkg::posMaskT lastHit;
    logic                lost;
    logic                ready;
    logic                won;
    hangmanPkg::posMaskT revealed;
    hangmanPkg::wordT    maskedWord;

    wordLoader wordLoader_inst (
        .clk         (clk),
        .nRst        (nRst),
        .wordReq     (wordReq),
        .wordLetter  (wordLetter),
        .wordAck     (wordAck),
        .loadAllowed (loadAllowed),
        .newWord     (newWord),
        .wordFull    (wordFull),
        .word        (word)
    );

    gameLogic gameLogic_inst (
        .clk          (clk),
        .nRst         (nRst),
        .guessReq     (guessReq),
        .guessLetter  (guessLetter),
        .guessAck     (guessAck),
        .guessRefused (guessRefused),
        .newWord      (newWord),
        .wordFull     (wordFull),
        .word         (word),
        .allRevealed  (allRevealed),
        .loadAllowed  (loadAllowed),
        .hitValid     (hitValid),
        .hitMask      (hitMask),
        .mistakes     (mistakes),
        .correct      (correct),
        .lastHit      (lastHit),
        .lost         (lost),
        .ready        (ready)
    );

    revealTracker revealTracker_inst (
        .clk         (clk),
        .nRst        (nRst),
        .newWord     (newWord),
        .wordFull    (wordFull),
        .word        (word),
        .hitValid    (hitValid),
        .hitMask     (hitMask),
        .allRevealed (allRevealed),
        .won         (won),
        .revealed    (revealed),
        .maskedWord  (maskedWord)
    );

    // status bundle for the outside
    assign status = '{
        mistakes:   mistakes,
        correct:    correct,
        lastHit:    lastHit,
        revealed:   revealed,
        won:        won,
        lost:       lost,
        ready:      ready,
        maskedWord: maskedWord
    };

endmodule

// File: bench/hangmanTb.sv
`timescale 1ns/1ps

module hangmanTb;

    localparam int WORD_LEN = 5;
    localparam int MAX_MISTAKES = 6;
    localparam int ACK_LATENCY = 8;
    localparam hangmanPkg::letterT HIDDEN = 8'h5f;
    // 6 random games of at most 25 guesses at about 14 cycles, plus the fixed tests
    localparam int TIMEOUT_CYCLES = 20000;

    logic                   clk = 1'b0;
    logic                   nRst;
    logic                   wordReq;
    hangmanPkg::letterT     wordLetter;
    logic                   wordAck;
    logic                   guessReq;
    hangmanPkg::letterT     guessLetter;
    logic                   guessAck;
    logic                   guessRefused;
    hangmanPkg::gameStatusT status;

    hangmanPkg::gameStatusT expSt;
    hangmanPkg::wordT       expWord;
    logic                   expRefused;
    logic                   ackPrev = 1'b0;
    int                     cycleCnt = 0;
    int                     errCount;
    int                     checkCount;
    int                     testErrs;
    int                     testChecks;
    integer                 seed;
    hangmanPkg::letterT     wordSeq[$];

    always #4 clk = ~clk;

    hangmanTop hangmanTop_inst (
        .clk          (clk),
        .nRst         (nRst),
        .wordReq      (wordReq),
        .wordLetter   (wordLetter),
        .wordAck      (wordAck),
        .guessReq     (guessReq),
        .guessLetter  (guessLetter),
        .guessAck     (guessAck),
        .guessRefused (guessRefused),
        .status       (status)
    );

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic isLetter(input hangmanPkg::letterT c);
        return (c >= "A" && c <= "Z") || (c >= "a" && c <= "z");
    endfunction

    function automatic hangmanPkg::letterT upperCase(input hangmanPkg::letterT c);
        if (c >= "a" && c <= "z") begin
            return c - 8'h20;
        end
        return c;
    endfunction

    // expected status after one accepted guess
    function automatic hangmanPkg::gameStatusT refGuess(input hangmanPkg::wordT w,
                                                         input hangmanPkg::gameStatusT s,
                                                         input hangmanPkg::letterT g);
        hangmanPkg::gameStatusT r;
        hangmanPkg::letterT     up;
        r = s;
        up = upperCase(g);
        for (int i = 0; i < WORD_LEN; i++) begin
            r.lastHit[i] = (w[39 - 8 * i -: 8] == up);
        end
        if (r.lastHit != '0) begin
            if (r.correct != 3'd7) begin
                r.correct = r.correct + 3'd1;
            end
        end else begin
            r.mistakes = r.mistakes + 3'd1;
        end
        r.revealed = s.revealed | r.lastHit;
        r.won = &r.revealed;
        r.lost = (int'(r.mistakes) == MAX_MISTAKES);
        r.ready = !(r.won || r.lost);
        for (int i = 0; i < WORD_LEN; i++) begin
            r.maskedWord[39 - 8 * i -: 8] = r.revealed[i] ? w[39 - 8 * i -: 8] : HIDDEN;
        end
        return r;
    endfunction

    function automatic hangmanPkg::letterT randLetter();
        logic [31:0]        r;
        hangmanPkg::letterT c;
        r = $random(seed);
        c = 8'h41 + 8'(r % 32'd26);
        if (r[8]) begin
            c = c + 8'h20;
        end
        return c;
    endfunction

    task automatic checkTrue(input logic cond, input string msg);
        checkCount++;
        assert (cond) else begin
            errCount++;
            $display("ERR %0t: %s", $time, msg);
        end
    endtask

    task automatic endTest(input int num, input string name);
        $display("test %0d %s: %0d checks, %0d errors", num, name,
                 checkCount - testChecks, errCount - testErrs);
        testChecks = checkCount;
        testErrs = errCount;
    endtask

    // compare on every guessAck rise, sampled mid-cycle
    always @(negedge clk) begin
        if (guessAck && !ackPrev) begin
            checkTrue(guessRefused == expRefused,
                      $sformatf("guessRefused %0b, expected %0b", guessRefused, expRefused));
            checkTrue(status == expSt,
                      $sformatf("status %h, expected %h", status, expSt));
        end
        ackPrev = guessAck;
    end

    task automatic sendWord(input hangmanPkg::letterT c);
        @(posedge clk);
        wordReq <= 1'b1;
        wordLetter <= c;
        do @(negedge clk); while (!wordAck);
        @(posedge clk);
        wordReq <= 1'b0;
        do @(negedge clk); while (wordAck);
    endtask

    task automatic loadWord();
        hangmanPkg::wordT w;
        w = '0;
        foreach (wordSeq[i]) begin
            sendWord(wordSeq[i]);
            if (isLetter(wordSeq[i])) begin
                w = {w[31:0], upperCase(wordSeq[i])};
            end
        end
        expWord = w;
        expSt = '0;
        expSt.ready = 1'b1;
        expSt.maskedWord = {WORD_LEN{HIDDEN}};
        checkTrue(status == expSt, $sformatf("status after load %h, expected %h", status, expSt));
    endtask

    task automatic sendGuess(input hangmanPkg::letterT g);
        int cycles;
        if (isLetter(g) && expSt.ready) begin
            expSt = refGuess(expWord, expSt, g);
            expRefused = 1'b0;
        end else begin
            expRefused = 1'b1;
        end
        @(posedge clk);
        guessReq <= 1'b1;
        guessLetter <= g;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!guessAck);
        // req sampled one edge after the drive, ack seen half a cycle after its edge
        if (!expRefused) begin
            checkTrue(cycles - 2 == ACK_LATENCY,
                      $sformatf("guessAck %0d cycles after sampled req, expected %0d",
                                cycles - 2, ACK_LATENCY));
        end
        @(posedge clk);
        guessReq <= 1'b0;
        do @(negedge clk); while (guessAck);
    endtask

    task automatic playRandomGame();
        int                 guesses;
        int                 pos;
        logic [31:0]        r;
        hangmanPkg::letterT g;
        wordSeq.delete();
        for (int i = 0; i < WORD_LEN; i++) begin
            wordSeq.push_back(randLetter());
        end
        loadWord();
        guesses = 0;
        while (expSt.ready && guesses < 40) begin
            r = $random(seed);
            if (guesses >= 20) begin
                // force progress, pick a hidden position
                for (int i = WORD_LEN - 1; i >= 0; i--) begin
                    if (!expSt.revealed[i]) begin
                        g = expWord[39 - 8 * i -: 8];
                    end
                end
            end else if (r[7:5] == 3'd0) begin
                g = 8'h30 + 8'(r % 32'd10);
            end else if (r[4]) begin
                pos = int'(r % 32'd5);
                g = expWord[39 - 8 * pos -: 8];
                if (r[3]) begin
                    g = g + 8'h20;
                end
            end else begin
                g = randLetter();
            end
            sendGuess(g);
            guesses++;
        end
        // game is over, this one is refused
        sendGuess(randLetter());
    endtask

    initial begin
        nRst = 1'b0;
        wordReq = 1'b0;
        wordLetter = '0;
        guessReq = 1'b0;
        guessLetter = '0;
        seed = 32'h77e6_0a76;
        errCount = 0;
        checkCount = 0;
        testErrs = 0;
        testChecks = 0;
        expRefused = 1'b0;
        expWord = '0;
        expSt = '0;
        expSt.maskedWord = {WORD_LEN{HIDDEN}};
        repeat (2) @(posedge clk);
        nRst <= 1'b1;
        @(negedge clk);

        checkTrue(!guessAck && !wordAck, "an ack is high right after reset");
        checkTrue(status == expSt, $sformatf("status after reset %h, expected %h", status, expSt));
        sendGuess("A");
        endTest(1, "after reset");

        // mixed case with one non-letter
        wordSeq = '{"h", "E", "#", "l", "L", "o"};
        loadWord();
        endTest(2, "loading a word");

        sendGuess("l");
        checkTrue(status.lastHit == 5'b01100 && status.correct == 3'd1,
                  "repeated letter L not scored on both positions");
        sendGuess("z");
        checkTrue(status.mistakes == 3'd1, "miss on Z not counted");
        endTest(3, "hits and misses");

        sendGuess("H");
        sendGuess("e");
        sendGuess("O");
        checkTrue(status.won && status.maskedWord == "HELLO", "full word not shown after win");
        sendGuess("x");
        endTest(4, "winning");

        wordSeq = '{"Q", "u", "i", "R", "k"};
        loadWord();
        for (int i = 0; i < MAX_MISTAKES; i++) begin
            sendGuess(8'("a" + i));
        end
        checkTrue(status.lost && !status.ready, "six misses did not end the game as lost");
        endTest(5, "losing");

        for (int i = 0; i < 6; i++) begin
            playRandomGame();
        end
        endTest(6, "random games");

        $display("checks: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: flist.f
hw/hangmanPkg.sv
hw/wordLoader.sv
hw/gameLogic.sv
hw/revealTracker.sv
hw/hangmanTop.sv
bench/hangmanTb.sv

// File: run.sh
#!/bin/sh
# compile and run the hangman testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module hangmanTb \
    --Mdir obj_dir -o hangmanSim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/hangmanSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    exit 1
fi
exit 0
